//--- include/game_defines.svh
/* Map and timing constants in pixels and frames. A player near an edge plus
   MUZZLE_OFFSET and one bullet step must still fit in COORD_W bits. */
`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

// Datapath widths
`define COORD_W 12
`define SPEED_W 5
`define KEY_W 8
`define ROLLOVER 4

// Legal map area, inclusive
`define MAP_MIN 64
`define MAP_MAX_X 3136
`define MAP_MAX_Y 2336

`define PLAYER_STEP 2
`define PLAYER_GAP 37
`define BULLET_SPEED 8
`define MUZZLE_OFFSET 41

`define BULLETS_PER_PLAYER 8
`define FIRE_COOLDOWN_FRAMES 36

// Spawn points
`define P1_START_X 700
`define P1_START_Y 700
`define P2_START_X 1500
`define P2_START_Y 1400

`endif

//--- design/game_pkg.sv
/* Shared game types. Widths come from the defines header. */
`default_nettype none

`include "game_defines.svh"

package game_pkg;

	// Map position, unsigned pixels
	typedef logic [`COORD_W-1:0] coord_t;

	// Per-frame step, signed
	typedef logic signed [`SPEED_W-1:0] velocity_t;

	typedef enum logic [1:0] {
		North = 2'd0,
		South = 2'd1,
		East  = 2'd2,
		West  = 2'd3
	} dir_t;

	typedef logic [`KEY_W-1:0] keycode_t;
	typedef logic [`ROLLOVER*`KEY_W-1:0] rollover_t;

endpackage

`default_nettype wire

//--- design/key_decoder.sv
/* Scancode 0 in a rollover byte means no key, so no key parameter may be 0.
   Movement is combinational, facing/aim/fireReq update on frameTick only. */
`default_nettype none
`timescale 1ns/1ps

`include "game_defines.svh"

module key_decoder #(
	parameter game_pkg::keycode_t NorthKey    = 8'h1A,
	parameter game_pkg::keycode_t WestKey     = 8'h04,
	parameter game_pkg::keycode_t SouthKey    = 8'h16,
	parameter game_pkg::keycode_t EastKey     = 8'h07,
	parameter game_pkg::keycode_t AimNorthKey = 8'h52,
	parameter game_pkg::keycode_t AimSouthKey = 8'h51,
	parameter game_pkg::keycode_t AimWestKey  = 8'h50,
	parameter game_pkg::keycode_t AimEastKey  = 8'h4F
) (
	input  logic                Clk,
	input  logic                arstN,
	input  logic                frameTick,
	input  game_pkg::rollover_t keys,
	output game_pkg::velocity_t moveX,
	output game_pkg::velocity_t moveY,
	output game_pkg::dir_t      facing,
	output game_pkg::dir_t      aim,
	output logic                fireReq
);
	import game_pkg::*;

	logic heldNorth, heldWest, heldSouth, heldEast;
	logic heldAimN, heldAimS, heldAimW, heldAimE;
	dir_t facingNext;
	dir_t aimNext;

	// Any of the rollover bytes matches
	function automatic logic isHeld(input rollover_t word, input keycode_t code);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < `ROLLOVER; i++)
		begin
			if (word[i*`KEY_W +: `KEY_W] == code)
				hit = 1'b1;
		end
		return hit;
	endfunction

	assign heldNorth = isHeld(keys, NorthKey);
	assign heldWest  = isHeld(keys, WestKey);
	assign heldSouth = isHeld(keys, SouthKey);
	assign heldEast  = isHeld(keys, EastKey);
	assign heldAimN  = isHeld(keys, AimNorthKey);
	assign heldAimS  = isHeld(keys, AimSouthKey);
	assign heldAimW  = isHeld(keys, AimWestKey);
	assign heldAimE  = isHeld(keys, AimEastKey);

	// Opposite keys cancel
	assign moveX = velocity_t'(`PLAYER_STEP) * (velocity_t'(heldEast) - velocity_t'(heldWest));
	assign moveY = velocity_t'(`PLAYER_STEP) * (velocity_t'(heldSouth) - velocity_t'(heldNorth));

	// Later keys in this order win
	always_comb
	begin
		facingNext = facing;
		aimNext = aim;
		if (heldNorth)
			facingNext = North;
		if (heldWest)
			facingNext = West;
		if (heldSouth)
			facingNext = South;
		if (heldEast)
			facingNext = East;
		if (heldAimN)
			aimNext = North;
		if (heldAimS)
			aimNext = South;
		if (heldAimW)
			aimNext = West;
		if (heldAimE)
			aimNext = East;
		if (heldAimN || heldAimS || heldAimW || heldAimE)
			facingNext = aimNext;
	end

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			facing <= North;
			aim <= North;
			fireReq <= 1'b0;
		end
		else if (frameTick)
		begin
			facing <= facingNext;
			aim <= aimNext;
			fireReq <= heldAimN | heldAimS | heldAimW | heldAimE;
		end
	end

endmodule

`default_nettype wire

//--- design/player_motion.sv
/* Both players move together or not at all when they would come within
   PLAYER_GAP on both axes. An axis step that leaves the map is dropped. */
`default_nettype none
`timescale 1ns/1ps

`include "game_defines.svh"

module player_motion (
	input  logic                Clk,
	input  logic                arstN,
	input  logic                frameTick,
	input  game_pkg::velocity_t move1X, move1Y, move2X, move2Y,
	output game_pkg::coord_t    x1, y1, x2, y2
);
	import game_pkg::*;

	localparam int SumW = `COORD_W + 2;

	logic signed [SumW-1:0] cand1X, cand1Y, cand2X, cand2Y;
	logic signed [SumW-1:0] diffX, diffY;
	logic tooClose;

	function automatic logic signed [SumW-1:0] absVal(input logic signed [SumW-1:0] v);
		return (v < 0) ? -v : v;
	endfunction

	function automatic logic inRange(input logic signed [SumW-1:0] c, input int maxVal);
		return (c >= `MAP_MIN) && (c <= maxVal);
	endfunction

	// Unclamped next positions
	assign cand1X = $signed({2'b00, x1}) + move1X;
	assign cand1Y = $signed({2'b00, y1}) + move1Y;
	assign cand2X = $signed({2'b00, x2}) + move2X;
	assign cand2Y = $signed({2'b00, y2}) + move2Y;

	assign diffX = cand1X - cand2X;
	assign diffY = cand1Y - cand2Y;
	assign tooClose = (absVal(diffX) < `PLAYER_GAP) && (absVal(diffY) < `PLAYER_GAP);

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			x1 <= coord_t'(`P1_START_X);
			y1 <= coord_t'(`P1_START_Y);
			x2 <= coord_t'(`P2_START_X);
			y2 <= coord_t'(`P2_START_Y);
		end
		else if (frameTick && !tooClose)
		begin
			x1 <= inRange(cand1X, `MAP_MAX_X) ? coord_t'(cand1X) : x1;
			y1 <= inRange(cand1Y, `MAP_MAX_Y) ? coord_t'(cand1Y) : y1;
			x2 <= inRange(cand2X, `MAP_MAX_X) ? coord_t'(cand2X) : x2;
			y2 <= inRange(cand2Y, `MAP_MAX_Y) ? coord_t'(cand2Y) : y2;
		end
	end

endmodule

`default_nettype wire

//--- design/fire_control.sv
/* A request with a full bank still starts the cooldown. Re-arming needs
   FIRE_COOLDOWN_FRAMES ticks and a released fire key. */
`default_nettype none
`timescale 1ns/1ps

`include "game_defines.svh"

module fire_control (
	input  logic                Clk,
	input  logic                arstN,
	input  logic                frameTick,
	input  logic                fireReq1, fireReq2,
	input  game_pkg::dir_t      aim1, aim2,
	input  game_pkg::velocity_t move1X, move1Y, move2X, move2Y,
	input  game_pkg::coord_t    x1, y1, x2, y2,
	input  logic [2*`BULLETS_PER_PLAYER-1:0] bulletActive,
	output logic [2*`BULLETS_PER_PLAYER-1:0] spawn,
	output game_pkg::coord_t    start1X, start1Y, start2X, start2Y,
	output game_pkg::velocity_t vel1X, vel1Y, vel2X, vel2Y
);
	import game_pkg::*;

	localparam int N = `BULLETS_PER_PLAYER;
	localparam int SlotW = $clog2(N);
	localparam int CountW = $clog2(`FIRE_COOLDOWN_FRAMES + 1);

	logic      req    [2];
	dir_t      aimDir [2];
	velocity_t moveX  [2];
	velocity_t moveY  [2];
	coord_t    posX   [2];
	coord_t    posY   [2];

	assign req = '{fireReq1, fireReq2};
	assign aimDir = '{aim1, aim2};
	assign moveX = '{move1X, move2X};
	assign moveY = '{move1Y, move2Y};
	assign posX = '{x1, x2};
	assign posY = '{y1, y2};

	// Index 0 is player 1, slots 0..N-1
	for (genvar p = 0; p < 2; p++)
	begin : bank
		logic [N-1:0] activeBank;
		logic [N-1:0] spawnBank;
		logic [SlotW-1:0] freeIdx;
		logic anyFree;
		logic coolActive;
		logic [CountW-1:0] coolCount;
		logic fire;
		coord_t startX, startY, nextStartX, nextStartY;
		velocity_t velX, velY, nextVelX, nextVelY;

		assign activeBank = bulletActive[p*N +: N];
		assign fire = req[p] && !coolActive;

		// Lowest inactive slot
		always_comb
		begin
			anyFree = 1'b0;
			freeIdx = '0;
			for (int i = N - 1; i >= 0; i--)
			begin
				if (!activeBank[i])
				begin
					anyFree = 1'b1;
					freeIdx = SlotW'(i);
				end
			end
		end

		// Muzzle point and speed along aim, shooter drift across it
		always_comb
		begin
			nextStartX = posX[p];
			nextStartY = posY[p];
			nextVelX = moveX[p];
			nextVelY = moveY[p];
			case (aimDir[p])
				North:
				begin
					nextStartY = posY[p] - coord_t'(`MUZZLE_OFFSET);
					nextVelY = -velocity_t'(`BULLET_SPEED);
				end
				South:
				begin
					nextStartY = posY[p] + coord_t'(`MUZZLE_OFFSET);
					nextVelY = velocity_t'(`BULLET_SPEED);
				end
				East:
				begin
					nextStartX = posX[p] + coord_t'(`MUZZLE_OFFSET);
					nextVelX = velocity_t'(`BULLET_SPEED);
				end
				West:
				begin
					nextStartX = posX[p] - coord_t'(`MUZZLE_OFFSET);
					nextVelX = -velocity_t'(`BULLET_SPEED);
				end
			endcase
		end

		always_ff @(posedge Clk or negedge arstN)
		begin
			if (!arstN)
			begin
				spawnBank <= '0;
				coolActive <= 1'b0;
				coolCount <= '0;
			end
			else
			begin
				spawnBank <= '0;
				if (fire)
				begin
					coolActive <= 1'b1;
					coolCount <= '0;
					if (anyFree)
						spawnBank[freeIdx] <= 1'b1;
				end
				else if (coolActive)
				begin
					if (coolCount == CountW'(`FIRE_COOLDOWN_FRAMES))
					begin
						if (!req[p])
							coolActive <= 1'b0;
					end
					else if (frameTick)
						coolCount <= coolCount + 1'b1;
				end
			end
		end

		always_ff @(posedge Clk)
		begin
			if (fire)
			begin
				startX <= nextStartX;
				startY <= nextStartY;
				velX <= nextVelX;
				velY <= nextVelY;
			end
		end
	end

	assign spawn = {bank[1].spawnBank, bank[0].spawnBank};
	assign start1X = bank[0].startX;
	assign start1Y = bank[0].startY;
	assign start2X = bank[1].startX;
	assign start2Y = bank[1].startY;
	assign vel1X = bank[0].velX;
	assign vel1Y = bank[0].velY;
	assign vel2X = bank[1].velX;
	assign vel2Y = bank[1].velY;

endmodule

`default_nettype wire

//--- design/bullet.sv
/* Position is only meaningful while active. A retiring bullet keeps its
   last in-map position. */
`default_nettype none
`timescale 1ns/1ps

`include "game_defines.svh"

module bullet (
	input  logic                Clk,
	input  logic                arstN,
	input  logic                frameTick,
	input  logic                load,
	input  game_pkg::coord_t    startX, startY,
	input  game_pkg::velocity_t velX, velY,
	output game_pkg::coord_t    posX, posY,
	output logic                active
);
	import game_pkg::*;

	localparam int SumW = `COORD_W + 2;

	velocity_t stepX, stepY;
	logic signed [SumW-1:0] nextX, nextY;
	logic inMap;

	assign nextX = $signed({2'b00, posX}) + stepX;
	assign nextY = $signed({2'b00, posY}) + stepY;
	assign inMap = (nextX >= `MAP_MIN) && (nextX <= `MAP_MAX_X) &&
		(nextY >= `MAP_MIN) && (nextY <= `MAP_MAX_Y);

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
			active <= 1'b0;
		else if (load)
			active <= 1'b1;
		else if (frameTick && active && !inMap)
			active <= 1'b0;
	end

	always_ff @(posedge Clk)
	begin
		if (load)
		begin
			posX <= startX;
			posY <= startY;
			stepX <= velX;
			stepY <= velY;
		end
		else if (frameTick && active && inMap)
		begin
			posX <= coord_t'(nextX);
			posY <= coord_t'(nextY);
		end
	end

endmodule

`default_nettype wire

//--- design/game_logic.sv
/* Player 1 uses USB HID scancodes, player 2 PS/2 set 2 make codes.
   frameTick must be a single-cycle pulse once per frame. */
`default_nettype none
`timescale 1ns/1ps

`include "game_defines.svh"

module game_logic (
	input  logic                Clk,
	input  logic                arstN,
	input  logic                frameTick,
	input  game_pkg::rollover_t keys1, keys2,
	output game_pkg::coord_t    x1, y1, x2, y2,
	output game_pkg::dir_t      facing1, facing2,
	output game_pkg::coord_t    bulletX [2*`BULLETS_PER_PLAYER],
	output game_pkg::coord_t    bulletY [2*`BULLETS_PER_PLAYER],
	output logic [2*`BULLETS_PER_PLAYER-1:0] bulletActive
);
	import game_pkg::*;

	localparam int N = `BULLETS_PER_PLAYER;

	velocity_t move1X, move1Y, move2X, move2Y;
	velocity_t vel1X, vel1Y, vel2X, vel2Y;
	coord_t start1X, start1Y, start2X, start2Y;
	dir_t aim1, aim2;
	logic fireReq1, fireReq2;
	logic [2*N-1:0] spawn;

	// WASD and arrow keys
	key_decoder #(
		.NorthKey(8'h1A), .WestKey(8'h04), .SouthKey(8'h16), .EastKey(8'h07),
		.AimNorthKey(8'h52), .AimSouthKey(8'h51), .AimWestKey(8'h50), .AimEastKey(8'h4F)
	) keysP1 (
		.Clk(Clk), .arstN(arstN), .frameTick(frameTick), .keys(keys1),
		.moveX(move1X), .moveY(move1Y), .facing(facing1), .aim(aim1), .fireReq(fireReq1)
	);

	// WASD and keypad arrows
	key_decoder #(
		.NorthKey(8'h1D), .WestKey(8'h1C), .SouthKey(8'h1B), .EastKey(8'h23),
		.AimNorthKey(8'h75), .AimSouthKey(8'h72), .AimWestKey(8'h6B), .AimEastKey(8'h74)
	) keysP2 (
		.Clk(Clk), .arstN(arstN), .frameTick(frameTick), .keys(keys2),
		.moveX(move2X), .moveY(move2Y), .facing(facing2), .aim(aim2), .fireReq(fireReq2)
	);

	player_motion motion (
		.Clk(Clk), .arstN(arstN), .frameTick(frameTick),
		.move1X(move1X), .move1Y(move1Y), .move2X(move2X), .move2Y(move2Y),
		.x1(x1), .y1(y1), .x2(x2), .y2(y2)
	);

	fire_control fire (
		.Clk(Clk), .arstN(arstN), .frameTick(frameTick),
		.fireReq1(fireReq1), .fireReq2(fireReq2), .aim1(aim1), .aim2(aim2),
		.move1X(move1X), .move1Y(move1Y), .move2X(move2X), .move2Y(move2Y),
		.x1(x1), .y1(y1), .x2(x2), .y2(y2), .bulletActive(bulletActive),
		.spawn(spawn), .start1X(start1X), .start1Y(start1Y), .start2X(start2X),
		.start2Y(start2Y), .vel1X(vel1X), .vel1Y(vel1Y), .vel2X(vel2X), .vel2Y(vel2Y)
	);

	// Lower bank belongs to player 1
	for (genvar i = 0; i < 2*N; i++)
	begin : slot
		bullet bulletInst (
			.Clk(Clk), .arstN(arstN), .frameTick(frameTick), .load(spawn[i]),
			.startX((i < N) ? start1X : start2X), .startY((i < N) ? start1Y : start2Y),
			.velX((i < N) ? vel1X : vel2X), .velY((i < N) ? vel1Y : vel2Y),
			.posX(bulletX[i]), .posY(bulletY[i]), .active(bulletActive[i])
		);
	end

endmodule

`default_nettype wire

//--- bench/game_logic_tb.sv
/* Rows run back to back, each one starting from the state the previous row left.
   One bullet slot is checked per row, and spawn latency only for newly fired slots. */
`default_nettype none
`timescale 1ns/1ps

`include "game_defines.svh"

module game_logic_tb;
	import game_pkg::*;

	localparam int NumRows = 19;
	localparam int NumBullets = 2*`BULLETS_PER_PLAYER;
	localparam int SpawnTimeout = 8;

	logic Clk;
	logic arstN;
	logic frameTick;
	rollover_t keys1, keys2;
	coord_t x1, y1, x2, y2;
	dir_t facing1, facing2;
	coord_t bulletX [NumBullets];
	coord_t bulletY [NumBullets];
	logic [NumBullets-1:0] bulletActive;

	// Stimulus and the expected state at the end of each row
	rollover_t rowKeys1 [NumRows];
	rollover_t rowKeys2 [NumRows];
	int rowFrames [NumRows];
	int expX1 [NumRows];
	int expY1 [NumRows];
	int expX2 [NumRows];
	int expY2 [NumRows];
	int expFacing1 [NumRows];
	int expFacing2 [NumRows];
	logic [NumBullets-1:0] expActive [NumRows];
	int expSlot [NumRows];
	int expBulletX [NumRows];
	int expBulletY [NumRows];
	int rowCount;
	int errors;

	game_logic game_logic_inst (
		.Clk(Clk), .arstN(arstN), .frameTick(frameTick), .keys1(keys1), .keys2(keys2),
		.x1(x1), .y1(y1), .x2(x2), .y2(y2), .facing1(facing1), .facing2(facing2),
		.bulletX(bulletX), .bulletY(bulletY), .bulletActive(bulletActive)
	);

	task automatic addRow(input rollover_t k1, input rollover_t k2, input int frames,
		input int px1, input int py1, input int px2, input int py2, input int f1,
		input int f2, input logic [NumBullets-1:0] act, input int slot, input int bx,
		input int by);
		rowKeys1[rowCount] = k1;
		rowKeys2[rowCount] = k2;
		rowFrames[rowCount] = frames;
		expX1[rowCount] = px1;
		expY1[rowCount] = py1;
		expX2[rowCount] = px2;
		expY2[rowCount] = py2;
		expFacing1[rowCount] = f1;
		expFacing2[rowCount] = f2;
		expActive[rowCount] = act;
		expSlot[rowCount] = slot;
		expBulletX[rowCount] = bx;
		expBulletY[rowCount] = by;
		rowCount++;
	endtask

	// P1 keys are USB codes, P2 keys PS/2 codes
	task automatic loadTable();
		addRow(32'h0, 32'h0, 0, 700, 700, 1500, 1400, North, North, 16'h0000, -1, 0, 0);
		addRow(32'h1A, 32'h0, 5, 700, 690, 1500, 1400, North, North, 16'h0000, -1, 0, 0);
		addRow(32'h071A, 32'h0, 4, 708, 682, 1500, 1400, East, North, 16'h0000, -1, 0, 0);
		// Line up on Y, then close in on X until the gap rule blocks
		addRow(32'h16, 32'h1D, 179, 708, 1040, 1500, 1042, South, North, 16'h0000, -1, 0, 0);
		addRow(32'h07, 32'h1C, 188, 1084, 1040, 1124, 1042, East, West, 16'h0000, -1, 0, 0);
		addRow(32'h07, 32'h1C, 5, 1084, 1040, 1124, 1042, East, West, 16'h0000, -1, 0, 0);
		// Top and bottom map limits
		addRow(32'h1A, 32'h1B, 660, 1084, 64, 1124, 2336, North, South, 16'h0000, -1, 0, 0);
		// Fire east while drifting south, then keep holding
		addRow(32'h4F16, 32'h0, 1, 1084, 66, 1124, 2336, East, South,
			16'h0001, 0, 1125, 66);
		addRow(32'h4F16, 32'h0, 3, 1084, 72, 1124, 2336, East, South,
			16'h0001, 0, 1149, 72);
		addRow(32'h0, 32'h0, 1, 1084, 72, 1124, 2336, East, South,
			16'h0001, 0, 1157, 74);
		addRow(32'h0, 32'h0, 32, 1084, 72, 1124, 2336, East, South,
			16'h0001, 0, 1413, 138);
		addRow(32'h4F, 32'h0, 1, 1084, 72, 1124, 2336, East, South,
			16'h0003, 1, 1125, 72);
		// Held fire key past the full cooldown gives no second shot
		addRow(32'h4F, 32'h0, 40, 1084, 72, 1124, 2336, East, South,
			16'h0003, 1, 1445, 72);
		// Player 2 bank starts at slot 8
		addRow(32'h0, 32'h75, 1, 1084, 72, 1124, 2336, East, North,
			16'h0103, 8, 1124, 2295);
		addRow(32'h0, 32'h0, 2, 1084, 72, 1124, 2336, East, North,
			16'h0103, 8, 1124, 2279);
		addRow(32'h16, 32'h0, 40, 1084, 152, 1124, 2336, South, North,
			16'h0103, 8, 1124, 1959);
		// Short shot at the top edge
		addRow(32'h52, 32'h0, 1, 1084, 152, 1124, 2336, North, North,
			16'h0107, 2, 1084, 111);
		addRow(32'h0, 32'h0, 5, 1084, 152, 1124, 2336, North, North,
			16'h0107, 2, 1084, 71);
		addRow(32'h0, 32'h0, 1, 1084, 152, 1124, 2336, North, North,
			16'h0103, 2, 1084, 71);
	endtask

	task automatic compareValue(input int got, input int expected, input string what);
		if (got != expected)
		begin
			errors++;
			$display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got,
				expected);
			$display("Finished with errors");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// Tick cycle plus three idle cycles
	task automatic runFrame(input int watchSlot);
		int waited;
		frameTick = 1'b1;
		@(negedge Clk);
		frameTick = 1'b0;
		waited = 1;
		if (watchSlot >= 0)
		begin
			while (!bulletActive[watchSlot] && waited < SpawnTimeout)
			begin
				@(negedge Clk);
				waited++;
			end
			if (!bulletActive[watchSlot])
			begin
				errors++;
				$display("Bullet slot %0d never became active after the fire key", watchSlot);
				$display("Finished with errors");
				$fatal(1, "spawn wait timed out");
			end
			// Rising edges from the tick edge to the first active sample
			compareValue(waited - 1, 2, $sformatf("spawn latency of slot %0d", watchSlot));
		end
		while (waited < 4)
		begin
			@(negedge Clk);
			waited++;
		end
	endtask

	task automatic checkRow(input int r);
		int slot;
		slot = expSlot[r];
		compareValue(x1, expX1[r], $sformatf("row %0d x1", r));
		compareValue(y1, expY1[r], $sformatf("row %0d y1", r));
		compareValue(x2, expX2[r], $sformatf("row %0d x2", r));
		compareValue(y2, expY2[r], $sformatf("row %0d y2", r));
		compareValue(facing1, expFacing1[r], $sformatf("row %0d facing1", r));
		compareValue(facing2, expFacing2[r], $sformatf("row %0d facing2", r));
		compareValue(bulletActive, expActive[r], $sformatf("row %0d bulletActive", r));
		if (slot >= 0)
		begin
			compareValue(bulletX[slot], expBulletX[r], $sformatf("row %0d bulletX", r));
			compareValue(bulletY[slot], expBulletY[r], $sformatf("row %0d bulletY", r));
		end
	endtask

	initial
	begin
		Clk = 1'b0;
		forever #5 Clk = ~Clk;
	end

	initial
	begin
		int watchSlot;
		logic [NumBullets-1:0] prevActive;
		arstN = 1'b0;
		frameTick = 1'b0;
		keys1 = '0;
		keys2 = '0;
		errors = 0;
		rowCount = 0;
		prevActive = '0;
		loadTable();
		repeat (3) @(negedge Clk);
		arstN = 1'b1;
		for (int r = 0; r < rowCount; r++)
		begin
			keys1 = rowKeys1[r];
			keys2 = rowKeys2[r];
			watchSlot = -1;
			// Latency is measured only where a slot newly fires
			if (expSlot[r] >= 0 && expActive[r][expSlot[r]] && !prevActive[expSlot[r]])
				watchSlot = expSlot[r];
			for (int f = 0; f < rowFrames[r]; f++)
				runFrame((f == 0) ? watchSlot : -1);
			checkRow(r);
			prevActive = expActive[r];
		end
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+include
design/game_pkg.sv
design/key_decoder.sv
design/player_motion.sv
design/fire_control.sv
design/bullet.sv
design/game_logic.sv
bench/game_logic_tb.sv
